//--- sources.f
if_pkg.sv
compressed_decoder.sv
dummy_inserter.sv
if_stage_checker.sv
prefetch_unit.sv
if_stage.sv
fetch_top.sv
tb_fetch_top.sv

//--- tb_fetch_top.sv
////////////////////////////////////////
// The memory model wraps at 1 KB and answers in order after 1 to 3 cycles.
// Inputs change 1 ns after the rising edge and outputs are sampled on it
////////////////////////////////////////
`timescale 1ns/1ps

module tb_fetch_top;
  import if_pkg::*;

  localparam int MEM_HW = 512;

  logic        clk;
  logic        rst_n;
  ctrl_fsm_t   ctrl;
  logic        mem_credit_i;
  logic        mem_rsp_valid_i;
  instr_t      mem_rsp_rdata_i;
  logic        id_ready_i;
  logic        mem_req_valid_o;
  fetch_req_t  mem_req_o;
  if_id_pipe_t if_id_pipe_o;

  integer      seed;
  logic [15:0] mem [MEM_HW];
  // Pending memory responses, each with the cycle in which it is due
  addr_t       rsp_addr_q [$];
  int          rsp_due_q [$];
  int          cyc;
  int          last_due;
  int          owed;
  int          req_total;
  int          credit_total;
  bit          withhold;
  // Accepted decode transfers of the running test
  if_id_pipe_t seen [$];
  if_id_pipe_t held;
  bit          held_valid;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          dummies_seen;
  bit          timed_out;

  fetch_top fetch_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctrl_fsm_i      (ctrl),
    .mem_credit_i    (mem_credit_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .id_ready_i      (id_ready_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .if_id_pipe_o    (if_id_pipe_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////
  // Encoding helpers and reference model
  ////////////////////////////////////////
  function automatic instr_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [4:0] rd);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic instr_t enc_r(input logic [4:0] rs2, input logic [4:0] rs1,
                                   input logic [4:0] rd);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  // CI format in quadrant 1, used for c.li and c.addi
  function automatic logic [15:0] c_ci(input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [5:0] imm);
    return {f3, imm[5], rd, imm[4:0], 2'b01};
  endfunction

  // CR format in quadrant 2, bit 12 picks c.add over c.mv
  function automatic logic [15:0] c_cr(input logic b12, input logic [4:0] rd,
                                       input logic [4:0] rs2);
    return {3'b100, b12, rd, rs2, 2'b10};
  endfunction

  function automatic logic [15:0] hw_at(input addr_t a);
    return mem[int'((a >> 1) % MEM_HW)];
  endfunction

  function automatic void put16(input addr_t a, input logic [15:0] h);
    mem[int'((a >> 1) % MEM_HW)] = h;
  endfunction

  function automatic void put32(input addr_t a, input instr_t w);
    put16(a, w[15:0]);
    put16(a + 32'd2, w[31:16]);
  endfunction

  // Expected 32-bit form of a halfword, raw when outside the supported set
  function automatic instr_t expand_rvc(input logic [15:0] h, output logic bad);
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd  = h[11:7];
    rs2 = h[6:2];
    imm = 12'($signed({h[12], h[6:2]}));
    bad = 1'b0;
    if (h[1:0] == 2'b01 && h[15:13] == 3'b010) return enc_i(imm, 5'd0, rd);
    if (h[1:0] == 2'b01 && h[15:13] == 3'b000) return enc_i(imm, rd, rd);
    if (h[1:0] == 2'b10 && h[15:12] == 4'b1000 && rs2 != 5'd0) return enc_r(rs2, 5'd0, rd);
    if (h[1:0] == 2'b10 && h[15:12] == 4'b1001 && rs2 != 5'd0) return enc_r(rs2, rd, rd);
    bad = 1'b1;
    return {16'h0000, h};
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR @ %0t: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////
  // Memory model with credit return
  ////////////////////////////////////////
  always @(posedge clk) begin
    int lat;
    int due;
    bit give;
    cyc++;
    if (rst_n && mem_req_valid_o) begin
      req_total++;
      // Every request must be covered by a credit that was already granted
      if (req_total > MEM_CREDITS + credit_total) begin
        report_error($sformatf("request %0d issued with only %0d credits granted",
                               req_total, MEM_CREDITS + credit_total));
      end
      if (mem_req_o.addr[1:0] != 2'b00) begin
        report_error($sformatf("request address %h not word aligned", mem_req_o.addr));
      end
      lat = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
      due = cyc + lat - 1;
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rsp_addr_q.push_back(mem_req_o.addr);
      rsp_due_q.push_back(due);
    end
    if (rst_n && mem_credit_i) credit_total++;
    give = (rsp_due_q.size() > 0) && (rsp_due_q[0] <= cyc);
    #1;
    mem_rsp_valid_i = 1'b0;
    mem_credit_i    = 1'b0;
    if (give) begin
      mem_rsp_valid_i = 1'b1;
      mem_rsp_rdata_i = {hw_at(rsp_addr_q[0] + 32'd2), hw_at(rsp_addr_q[0])};
      void'(rsp_addr_q.pop_front());
      void'(rsp_due_q.pop_front());
      owed++;
    end
    // Withheld credits pile up and come back one per cycle later
    if (!withhold && owed > 0) begin
      mem_credit_i = 1'b1;
      owed--;
    end
  end

  ////////////////////////////////////////
  // Decode port monitor
  ////////////////////////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      if (ctrl.halt_if && !ctrl.kill_if && if_id_pipe_o.instr_valid) begin
        report_error("instr_valid high during halt");
      end
      if (ctrl.kill_if && if_id_pipe_o.instr_valid) begin
        report_error("instr_valid high during kill");
      end
      if (held_valid && if_id_pipe_o.instr_valid && if_id_pipe_o !== held) begin
        report_error($sformatf("output changed under back-pressure, pc %h to %h",
                               held.pc, if_id_pipe_o.pc));
      end
      if (ctrl.kill_if) begin
        held_valid = 1'b0;
      end else if (if_id_pipe_o.instr_valid) begin
        if (id_ready_i) begin
          seen.push_back(if_id_pipe_o);
          held_valid = 1'b0;
        end else begin
          held       = if_id_pipe_o;
          held_valid = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Test helpers
  ////////////////////////////////////////
  function automatic int real_count();
    int n;
    n = 0;
    foreach (seen[i]) if (!seen[i].dummy) n++;
    return n;
  endfunction

  task automatic redirect(input addr_t target, input priv_lvl_t priv, input logic dummies);
    @(posedge clk);
    #1;
    ctrl.kill_if  = 1'b1;
    ctrl.pc_set   = 1'b1;
    ctrl.pc       = target;
    ctrl.priv_lvl = priv;
    ctrl.dummy_en = dummies;
    @(posedge clk);
    #1;
    ctrl.kill_if = 1'b0;
    ctrl.pc_set  = 1'b0;
    seen.delete();
  endtask

  task automatic wait_items(input int need, input int limit, input string what);
    int cycles;
    cycles = 0;
    while (real_count() < need && cycles < limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (real_count() < need) begin
      $display("Timeout: %s received %0d of %0d instructions in %0d cycles",
               what, real_count(), need, limit);
      timed_out = 1'b1;
    end
  endtask

  // Walks the reference list from start and compares it with the captured stream
  task automatic check_stream(input string name, input addr_t start, input priv_lvl_t priv,
                              input int n, input bit dummies_ok);
    addr_t       pc;
    logic [15:0] lo;
    instr_t      exp_instr;
    logic        exp_c;
    logic        exp_ill;
    int          pos;
    bit          prev_dummy;
    if_id_pipe_t got;
    pc         = start;
    pos        = 0;
    prev_dummy = 1'b0;
    for (int i = 0; i < n; i++) begin
      lo = hw_at(pc);
      if (lo[1:0] != 2'b11) begin
        exp_instr = expand_rvc(lo, exp_ill);
        exp_c     = 1'b1;
      end else begin
        exp_instr = {hw_at(pc + 32'd2), lo};
        exp_c     = 1'b0;
        exp_ill   = 1'b0;
      end
      // Dummy slots are checked here and then stepped over
      while (dummies_ok && pos < seen.size() && seen[pos].dummy) begin
        got = seen[pos];
        if (got.instr !== enc_i(12'h000, 5'd0, 5'd0) || got.compressed || got.illegal_c) begin
          report_error($sformatf("%s dummy slot carries %h", name, got.instr));
        end
        if (prev_dummy) report_error($sformatf("%s two dummy slots in a row", name));
        prev_dummy = 1'b1;
        dummies_seen++;
        pos++;
      end
      if (pos >= seen.size()) begin
        $display("%s: stream ended after %0d of %0d instructions", name, i, n);
        errors++;
        return;
      end
      got = seen[pos];
      pos++;
      prev_dummy = 1'b0;
      if (got.instr !== exp_instr || got.pc !== pc || got.priv_lvl !== priv ||
          got.compressed !== exp_c || got.illegal_c !== exp_ill || got.dummy !== 1'b0) begin
        report_error($sformatf("%s item %0d got pc %h instr %h priv %0d c%b i%b d%b, %s",
                               name, i, got.pc, got.instr, got.priv_lvl, got.compressed,
                               got.illegal_c, got.dummy,
                               $sformatf("expected pc %h instr %h priv %0d c%b i%b",
                                         pc, exp_instr, priv, exp_c, exp_ill)));
      end
      pc = pc + (exp_c ? 32'd2 : 32'd4);
    end
  endtask

  task automatic close_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before || timed_out) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic test_sequential();
    int e;
    e = errors;
    wait_items(8, 200, "sequential");
    if (!timed_out) check_stream("sequential", 32'h000, PRIV_LVL_M, 8, 1'b0);
    close_test("sequential", e);
  endtask

  task automatic test_mixed();
    int e;
    e = errors;
    redirect(32'h100, PRIV_LVL_M, 1'b0);
    wait_items(10, 200, "mixed");
    if (!timed_out) check_stream("mixed", 32'h100, PRIV_LVL_M, 10, 1'b0);
    close_test("mixed", e);
  endtask

  task automatic test_kill();
    int e;
    e = errors;
    redirect(32'h000, PRIV_LVL_M, 1'b0);
    wait_items(3, 200, "kill old path");
    // Kill while the old path is still streaming
    if (!timed_out) redirect(32'h182, PRIV_LVL_U, 1'b0);
    if (!timed_out) wait_items(12, 300, "kill new path");
    if (!timed_out) check_stream("kill", 32'h182, PRIV_LVL_U, 12, 1'b0);
    close_test("kill", e);
  endtask

  task automatic test_halt_stall();
    int e;
    int cycles;
    e = errors;
    redirect(32'h100, PRIV_LVL_M, 1'b0);
    cycles = 0;
    while (real_count() < 20 && cycles < 800) begin
      @(posedge clk);
      #1;
      ctrl.halt_if = (($random(seed) & 3) == 0);
      id_ready_i   = $random(seed) & 1;
      cycles++;
    end
    ctrl.halt_if = 1'b0;
    id_ready_i   = 1'b1;
    if (real_count() < 20) begin
      $display("Timeout: halt and stall test stuck at %0d instructions", real_count());
      timed_out = 1'b1;
    end
    if (!timed_out) check_stream("halt_stall", 32'h100, PRIV_LVL_M, 20, 1'b0);
    close_test("halt_stall", e);
  endtask

  task automatic test_credits();
    int e;
    int req_start;
    e = errors;
    withhold = 1'b1;
    redirect(32'h000, PRIV_LVL_M, 1'b0);
    req_start = req_total;
    repeat (30) @(posedge clk);
    #1;
    // Without returned credits at most the reset grant can be spent
    if (req_total - req_start > MEM_CREDITS) begin
      report_error($sformatf("%0d requests while credits were withheld",
                             req_total - req_start));
    end
    withhold = 1'b0;
    wait_items(12, 300, "credits");
    if (!timed_out) check_stream("credits", 32'h000, PRIV_LVL_M, 12, 1'b0);
    close_test("credits", e);
  endtask

  task automatic test_dummies();
    int e;
    e = errors;
    dummies_seen = 0;
    redirect(32'h100, PRIV_LVL_M, 1'b1);
    // More slots than the LFSR period, so at least one dummy must show up
    wait_items(260, 5000, "dummies");
    if (!timed_out) begin
      check_stream("dummies", 32'h100, PRIV_LVL_M, 260, 1'b1);
      if (dummies_seen == 0) begin
        $display("dummies: no dummy slot appeared in a full LFSR period");
        errors++;
      end
    end
    ctrl.dummy_en = 1'b0;
    close_test("dummies", e);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    seed            = 32'h9748_cd01;
    rst_n           = 1'b0;
    ctrl            = '0;
    ctrl.priv_lvl   = PRIV_LVL_M;
    mem_credit_i    = 1'b0;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_rdata_i = '0;
    id_ready_i      = 1'b1;
    // Fill with addi words whose immediate is the word index
    for (int w = 0; w < MEM_HW / 2; w++) begin
      put32(addr_t'(w * 4), enc_i(12'(w), 5'd1, 5'd2));
    end
    for (int i = 0; i < 8; i++) begin
      put32(addr_t'(i * 4), enc_r(5'(i + 1), 5'(i + 2), 5'(i + 3)));
    end
    // Mixed code, the add at 0x10A straddles two words
    put16(32'h100, c_ci(3'b010, 5'd5, 6'd3));
    put16(32'h102, c_ci(3'b000, 5'd5, 6'h3f));
    put32(32'h104, enc_i(12'd7, 5'd5, 5'd6));
    put16(32'h108, c_cr(1'b0, 5'd7, 5'd6));
    put32(32'h10A, enc_r(5'd6, 5'd7, 5'd8));
    put16(32'h10E, c_cr(1'b1, 5'd8, 5'd5));
    put16(32'h110, {3'b010, 1'b0, 5'd5, 5'd4, 2'b10});
    put16(32'h112, c_ci(3'b010, 5'd9, 6'h3e));
    put32(32'h114, enc_i(12'h123, 5'd9, 5'd10));
    // Redirect target at 0x182, the halfword below it is never executed
    put16(32'h180, c_cr(1'b0, 5'd11, 5'd12));
    put32(32'h182, enc_r(5'd12, 5'd11, 5'd13));
    put16(32'h186, c_ci(3'b010, 5'd14, 6'h21));
    put32(32'h188, enc_i(12'hfff, 5'd14, 5'd15));
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_sequential();
    if (!timed_out) test_mixed();
    if (!timed_out) test_kill();
    if (!timed_out) test_halt_stall();
    if (!timed_out) test_credits();
    if (!timed_out) test_dummies();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- fetch_top.sv
////////////////////////////////////////
// Controller signals arrive unregistered from outside
////////////////////////////////////////
`timescale 1ns/1ps

module fetch_top (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  logic                mem_credit_i,
  input  logic                mem_rsp_valid_i,
  input  if_pkg::instr_t      mem_rsp_rdata_i,
  input  logic                id_ready_i,
  output logic                mem_req_valid_o,
  output if_pkg::fetch_req_t  mem_req_o,
  output if_pkg::if_id_pipe_t if_id_pipe_o
);
  import if_pkg::*;

  // Prefetch FIFO head toward the aligner
  logic   word_valid;
  instr_t word;
  addr_t  word_addr;
  logic   pop;

  prefetch_unit prefetch_unit_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .kill_i          (ctrl_fsm_i.kill_if),
    .branch_addr_i   (ctrl_fsm_i.pc),
    .mem_credit_i    (mem_credit_i),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .pop_i           (pop),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_o       (mem_req_o),
    .word_valid_o    (word_valid),
    .word_o          (word),
    .word_addr_o     (word_addr)
  );

  if_stage if_stage_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_fsm_i   (ctrl_fsm_i),
    .id_ready_i   (id_ready_i),
    .word_valid_i (word_valid),
    .word_i       (word),
    .word_addr_i  (word_addr),
    .pop_o        (pop),
    .if_id_pipe_o (if_id_pipe_o)
  );

endmodule

//--- if_stage.sv
////////////////////////////////////////
// Words come in word aligned and in order. A kill is expected
// with pc_set, or the old PC carries on
////////////////////////////////////////
`timescale 1ns/1ps

module if_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input  logic                id_ready_i,
  input  logic                word_valid_i,
  input  if_pkg::instr_t      word_i,
  input  if_pkg::addr_t       word_addr_i,
  output logic                pop_o,
  output if_pkg::if_id_pipe_t if_id_pipe_o
);
  import if_pkg::*;

  // Upper half of the last popped word, still to be used
  logic [15:0] residue_q;
  logic        residue_valid_q;
  // Address of the next instruction to assemble
  addr_t       pc_q;
  priv_lvl_t   priv_q;
  if_id_pipe_t out_q;
  logic        out_valid_q;

  logic        instr_avail;
  logic        consume_word;
  logic        residue_valid_d;
  instr_t      raw_instr;
  addr_t       instr_pc;
  instr_t      dec_instr;
  logic        dec_compressed;
  logic        dec_illegal;
  logic        transfer;
  logic        out_free;
  logic        if_ready;
  logic        load;
  logic        step;
  logic        advance;
  logic        dummy_insert;
  fetch_req_t  word_req;

  ////////////////////////////////////////
  // Halfword aligner
  ////////////////////////////////////////
  always_comb begin
    instr_avail     = 1'b0;
    consume_word    = 1'b0;
    residue_valid_d = residue_valid_q;
    raw_instr       = {16'h0000, residue_q};
    instr_pc        = pc_q;
    if (residue_valid_q) begin
      if (residue_q[1:0] != 2'b11) begin
        // Compressed instruction held entirely in the residue
        instr_avail     = 1'b1;
        residue_valid_d = 1'b0;
      end else if (word_valid_i) begin
        // Straddling instruction completes with the low half of this word
        instr_avail  = 1'b1;
        consume_word = 1'b1;
        raw_instr    = {word_i[15:0], residue_q};
      end
    end else if (word_valid_i) begin
      consume_word = 1'b1;
      instr_pc     = {word_addr_i[31:2], pc_q[1], 1'b0};
      if (pc_q[1]) begin
        // Halfword target, so the low half belongs to the old path
        if (word_i[17:16] != 2'b11) begin
          instr_avail = 1'b1;
          raw_instr   = {16'h0000, word_i[31:16]};
        end else begin
          residue_valid_d = 1'b1;
        end
      end else if (word_i[1:0] != 2'b11) begin
        instr_avail     = 1'b1;
        raw_instr       = {16'h0000, word_i[15:0]};
        residue_valid_d = 1'b1;
      end else begin
        instr_avail = 1'b1;
        raw_instr   = word_i;
      end
    end
  end

  compressed_decoder compressed_decoder_inst (
    .instr_i      (raw_instr),
    .instr_o      (dec_instr),
    .compressed_o (dec_compressed),
    .illegal_c_o  (dec_illegal)
  );

  ////////////////////////////////////////
  // Handshake toward decode
  ////////////////////////////////////////
  // Halt and kill hide whatever sits in the output register
  always_comb begin
    if_id_pipe_o             = out_q;
    if_id_pipe_o.instr_valid = out_valid_q && !ctrl_fsm_i.halt_if && !ctrl_fsm_i.kill_if;
  end

  assign transfer = if_id_pipe_o.instr_valid && id_ready_i;
  assign out_free = !out_valid_q || transfer;
  assign if_ready = ctrl_fsm_i.kill_if || (!ctrl_fsm_i.halt_if && out_free);
  assign load     = if_ready && !ctrl_fsm_i.kill_if;
  // A dummy slot fills the register but leaves the aligner alone
  assign step     = load && !dummy_insert;
  assign advance  = load && (dummy_insert || instr_avail);
  assign pop_o    = step && consume_word;

  dummy_inserter dummy_inserter_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (ctrl_fsm_i.dummy_en && load && instr_avail),
    .advance_i      (advance),
    .dummy_insert_o (dummy_insert)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      residue_valid_q <= 1'b0;
      pc_q            <= BOOT_ADDR;
      priv_q          <= PRIV_LVL_M;
      out_valid_q     <= 1'b0;
    end else if (ctrl_fsm_i.kill_if) begin
      residue_valid_q <= 1'b0;
      out_valid_q     <= 1'b0;
      // The new path runs at the level given with the redirect
      priv_q          <= ctrl_fsm_i.priv_lvl;
      if (ctrl_fsm_i.pc_set) begin
        pc_q <= ctrl_fsm_i.pc;
      end
    end else begin
      if (load) begin
        out_valid_q <= advance;
      end
      if (step) begin
        residue_valid_q <= residue_valid_d;
        if (instr_avail) begin
          pc_q <= instr_pc + (dec_compressed ? 32'd2 : 32'd4);
        end else begin
          pc_q <= instr_pc;
        end
      end
    end
  end

  // Residue and output payload
  always_ff @(posedge clk) begin
    if (pop_o) begin
      residue_q <= word_i[31:16];
    end
    if (advance) begin
      out_q.instr_valid <= 1'b1;
      out_q.pc          <= instr_pc;
      out_q.priv_lvl    <= priv_q;
      out_q.instr       <= dummy_insert ? DUMMY_INSTR : dec_instr;
      out_q.compressed  <= dec_compressed && !dummy_insert;
      out_q.illegal_c   <= dec_illegal && !dummy_insert;
      out_q.dummy       <= dummy_insert;
    end
  end

  // The checker watches word addresses as they leave the prefetch FIFO
  assign word_req.addr = word_addr_i;

  if_stage_checker if_stage_checker_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_fsm_i    (ctrl_fsm_i),
    .if_ready      (if_ready),
    .if_id_pipe_o  (if_id_pipe_o),
    .dummy_insert  (dummy_insert),
    .pop           (pop_o),
    .mem_req       (word_req),
    .mem_req_valid (word_valid_i)
  );

endmodule

//--- prefetch_unit.sv
////////////////////////////////////////
// The memory answers in order and never refuses a request.
// Credits come back one per pulse of mem_credit_i
////////////////////////////////////////
`timescale 1ns/1ps

module prefetch_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               kill_i,
  input  if_pkg::addr_t      branch_addr_i,
  input  logic               mem_credit_i,
  input  logic               mem_rsp_valid_i,
  input  if_pkg::instr_t     mem_rsp_rdata_i,
  input  logic               pop_i,
  output logic               mem_req_valid_o,
  output if_pkg::fetch_req_t mem_req_o,
  output logic               word_valid_o,
  output if_pkg::instr_t     word_o,
  output if_pkg::addr_t      word_addr_o
);
  import if_pkg::*;

  // Fetch only starts one cycle after reset is released
  logic   run_q;
  addr_t  req_addr_q;
  // Address of the next live response
  addr_t  rsp_addr_q;
  cnt_t   credits_q;
  // Live requests whose data will be kept
  cnt_t   outstanding_q;
  // Requests from a killed path whose data is thrown away
  cnt_t   drop_q;
  cnt_t   fifo_cnt_q;
  ptr_t   wr_ptr_q;
  ptr_t   rd_ptr_q;
  instr_t fifo_data_q [PREFETCH_DEPTH];
  addr_t  fifo_addr_q [PREFETCH_DEPTH];

  logic   rsp_live;
  logic   rsp_drop;
  logic   push;
  logic   pop;
  addr_t  branch_word;

  assign branch_word = {branch_addr_i[31:2], 2'b00};

  // A request needs a credit and a free FIFO slot not already promised to
  // another live request
  assign mem_req_valid_o = run_q && !kill_i && (credits_q != '0) &&
                           ((fifo_cnt_q + outstanding_q) < PREFETCH_DEPTH);
  assign mem_req_o.addr  = req_addr_q;

  // Old-path responses are drained before any live one can arrive
  assign rsp_drop = mem_rsp_valid_i && (drop_q != '0);
  assign rsp_live = mem_rsp_valid_i && (drop_q == '0);
  assign push     = rsp_live && !kill_i;
  assign pop      = pop_i && word_valid_o && !kill_i;

  assign word_valid_o = (fifo_cnt_q != '0);
  assign word_o       = fifo_data_q[rd_ptr_q];
  assign word_addr_o  = fifo_addr_q[rd_ptr_q];

  ////////////////////////////////////////
  // Counters and pointers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q         <= 1'b0;
      req_addr_q    <= BOOT_ADDR;
      rsp_addr_q    <= BOOT_ADDR;
      credits_q     <= cnt_t'(MEM_CREDITS);
      outstanding_q <= '0;
      drop_q        <= '0;
      fifo_cnt_q    <= '0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end else begin
      run_q     <= 1'b1;
      credits_q <= credits_q - cnt_t'(mem_req_valid_o) + cnt_t'(mem_credit_i);
      if (kill_i) begin
        req_addr_q    <= branch_word;
        rsp_addr_q    <= branch_word;
        // Everything still in flight now returns data for the dead path
        drop_q        <= drop_q + outstanding_q - cnt_t'(mem_rsp_valid_i);
        outstanding_q <= '0;
        fifo_cnt_q    <= '0;
        wr_ptr_q      <= '0;
        rd_ptr_q      <= '0;
      end else begin
        if (mem_req_valid_o) begin
          req_addr_q <= req_addr_q + 32'd4;
        end
        if (push) begin
          rsp_addr_q <= rsp_addr_q + 32'd4;
          wr_ptr_q   <= wr_ptr_q + ptr_t'(1);
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
        outstanding_q <= outstanding_q + cnt_t'(mem_req_valid_o) - cnt_t'(rsp_live);
        drop_q        <= drop_q - cnt_t'(rsp_drop);
        fifo_cnt_q    <= fifo_cnt_q + cnt_t'(push) - cnt_t'(pop);
      end
    end
  end

  // Response storage, each word kept with its fetch address
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_data_q[wr_ptr_q] <= mem_rsp_rdata_i;
      fifo_addr_q[wr_ptr_q] <= rsp_addr_q;
    end
  end

endmodule

//--- if_stage_checker.sv
////////////////////////////////////////
// Simulation only. Failures are reported with $error
////////////////////////////////////////
`timescale 1ns/1ps

module if_stage_checker (
  input logic                clk,
  input logic                rst_n,
  input if_pkg::ctrl_fsm_t   ctrl_fsm_i,
  input logic                if_ready,
  input if_pkg::if_id_pipe_t if_id_pipe_o,
  input logic                dummy_insert,
  input logic                pop,
  input if_pkg::fetch_req_t  mem_req,
  input logic                mem_req_valid
);
  import if_pkg::*;

  // Pending level change and the level it asked for
  logic      priv_change_q;
  priv_lvl_t new_priv_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_change_q <= 1'b0;
      new_priv_q    <= PRIV_LVL_M;
    end else if (ctrl_fsm_i.kill_if && (ctrl_fsm_i.priv_lvl != new_priv_q)) begin
      priv_change_q <= 1'b1;
      new_priv_q    <= ctrl_fsm_i.priv_lvl;
    end else if (if_id_pipe_o.instr_valid) begin
      priv_change_q <= 1'b0;
    end
  end

  // Fetch addresses reaching the aligner are word aligned
  a_req_aligned :
    assert property (@(posedge clk) disable iff (!rst_n)
                     mem_req_valid |-> (mem_req.addr[1:0] == 2'b00))
      else $error("Fetch address not word aligned");

  a_halt :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (ctrl_fsm_i.halt_if && !ctrl_fsm_i.kill_if)
                     |-> (!if_ready && !if_id_pipe_o.instr_valid))
      else $error("Halt must give not ready and not valid");

  a_kill :
    assert property (@(posedge clk) disable iff (!rst_n)
                     ctrl_fsm_i.kill_if |-> (if_ready && !if_id_pipe_o.instr_valid))
      else $error("Kill must give ready and not valid");

  // The dummy slot must leave the prefetch FIFO untouched
  a_no_pop_on_dummy :
    assert property (@(posedge clk) disable iff (!rst_n)
                     dummy_insert |-> !pop)
      else $error("Prefetch FIFO popped during a dummy slot");

  a_no_back_to_back_dummy :
    assert property (@(posedge clk) disable iff (!rst_n)
                     dummy_insert |-> !$past(dummy_insert))
      else $error("Two dummy slots in a row");

  // First instruction after a level change runs at the new level
  a_priv_lvl_change :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (priv_change_q && if_id_pipe_o.instr_valid)
                     |-> (if_id_pipe_o.priv_lvl == new_priv_q))
      else $error("Wrong privilege level sent to decode");

endmodule

//--- dummy_inserter.sv
////////////////////////////////////////
// Slot timing is pseudo random, not a security grade source
////////////////////////////////////////
`timescale 1ns/1ps

module dummy_inserter (
  input  logic clk,
  input  logic rst_n,
  input  logic enable_i,
  input  logic advance_i,
  output logic dummy_insert_o
);
  import if_pkg::*;

  lfsr_t lfsr_q;
  // Set while the latest loaded slot was a dummy
  logic  last_dummy_q;
  logic  feedback;

  // Taps of x^8 + x^6 + x^5 + x^4 + 1, a maximal length polynomial
  assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // Roughly one slot in eight, never two in a row
  assign dummy_insert_o = enable_i && (lfsr_q[2:0] == 3'b000) && !last_dummy_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr_q       <= LFSR_SEED;
      last_dummy_q <= 1'b0;
    end else if (advance_i) begin
      lfsr_q       <= {lfsr_q[6:0], feedback};
      last_dummy_q <= dummy_insert_o;
    end
  end

endmodule

//--- compressed_decoder.sv
////////////////////////////////////////
// Expands c.li, c.addi, c.mv and c.add only. Every other RVC
// form passes through raw with illegal_c_o set
////////////////////////////////////////
`timescale 1ns/1ps

module compressed_decoder (
  input  if_pkg::instr_t instr_i,
  output if_pkg::instr_t instr_o,
  output logic           compressed_o,
  output logic           illegal_c_o
);
  import if_pkg::*;

  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm;

  // CI and CR fields share these bit positions
  assign rd  = instr_i[11:7];
  assign rs2 = instr_i[6:2];
  // Sign-extended 6-bit CI immediate
  assign imm = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};

  // Quadrants 0 to 2 are compressed, quadrant 3 is a full word
  assign compressed_o = (instr_i[1:0] != 2'b11);

  always_comb begin
    instr_o     = instr_i;
    illegal_c_o = 1'b0;
    if (compressed_o) begin
      // Assume unsupported until one of the known forms matches
      illegal_c_o = 1'b1;
      case ({instr_i[1:0], instr_i[15:13]})
        // c.addi becomes addi rd, rd, imm
        5'b01_000: begin
          instr_o     = {imm, rd, 3'b000, rd, OPC_OP_IMM};
          illegal_c_o = 1'b0;
        end
        // c.li becomes addi rd, x0, imm
        5'b01_010: begin
          instr_o     = {imm, 5'd0, 3'b000, rd, OPC_OP_IMM};
          illegal_c_o = 1'b0;
        end
        // With rs2 zero this is c.jr, c.jalr or c.ebreak, none supported
        5'b10_100: begin
          if (rs2 != 5'd0) begin
            if (instr_i[12]) begin
              // c.add becomes add rd, rd, rs2
              instr_o = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};
            end else begin
              // c.mv becomes add rd, x0, rs2
              instr_o = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};
            end
            illegal_c_o = 1'b0;
          end
        end
        default: begin
          illegal_c_o = 1'b1;
        end
      endcase
    end
  end

endmodule

//--- if_pkg.sv
////////////////////////////////////////
// Only U and M privilege exist. Counter widths assume that
// PREFETCH_DEPTH is a power of two
////////////////////////////////////////
package if_pkg;

  // Prefetch buffer size, which also caps requests in flight plus words held
  localparam int PREFETCH_DEPTH = 4;
  // Credits the memory grants out of reset
  localparam int MEM_CREDITS    = 2;
  localparam int CNT_W          = $clog2(PREFETCH_DEPTH + 1);
  localparam int PTR_W          = $clog2(PREFETCH_DEPTH);

  typedef logic [31:0]      addr_t;
  typedef logic [31:0]      instr_t;
  typedef logic [7:0]       lfsr_t;
  typedef logic [CNT_W-1:0] cnt_t;
  typedef logic [PTR_W-1:0] ptr_t;

  // Major opcodes produced by the RVC expansion
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // Fetch starts here after reset
  localparam addr_t  BOOT_ADDR   = 32'h0000_0000;
  // addi x0, x0, 0
  localparam instr_t DUMMY_INSTR = {12'h000, 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
  // Low three bits nonzero so no dummy slot is due right out of reset
  localparam lfsr_t  LFSR_SEED   = 8'hA5;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // Controller outputs that steer fetch
  typedef struct packed {
    logic      halt_if;
    logic      kill_if;
    logic      pc_set;
    addr_t     pc;
    priv_lvl_t priv_lvl;
    logic      dummy_en;
  } ctrl_fsm_t;

  // Memory request payload, the address is always word aligned
  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  // Fetch to decode pipeline register
  typedef struct packed {
    logic      instr_valid;
    instr_t    instr;
    addr_t     pc;
    priv_lvl_t priv_lvl;
    logic      compressed;
    logic      illegal_c;
    logic      dummy;
  } if_id_pipe_t;

endpackage
